// File: sim.f
verilog/lsu_pkg.sv
verilog/bus_pkg.sv
verilog/dcache.sv
verilog/mem_block.sv
verilog/page_walker.sv
verilog/wb_arbiter.sv
verilog/lsu_top.sv
dv/lsu_tb_properties.sv
dv/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the load/store unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module lsu_tb -f sim.f -Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0

// File: dv/lsu_tb.sv
// Load/store unit testbench
// Wishbone memory model, LFSR stimulus and an in-order reference model
`timescale 1ns/10ps
`default_nettype none

module lsu_tb
  import lsu_pkg::*, bus_pkg::*;
();

  localparam int MEM_WORDS   = 16384;
  localparam int PT_WORD     = 32'h0000_8000 >> 2;
  localparam int N_OPS       = 124;
  localparam int CYCLE_LIMIT = N_OPS * 40;

  // Expected write-back record
  typedef struct packed {
    logic [ROB_W-1:0]   rob;
    logic [PDEST_W-1:0] pdest;
    mem_op_e            op;
    logic               we;
    logic [31:0]        wdata;
    logic               excp;
    logic [31:0]        paddr;
    logic [31:0]        vaddr;
    logic               chk_wdata;
    logic               chk_paddr;
  } exp_t;

  logic     clk;
  logic     rst_n;
  mem_exe_t exe_i;
  logic     exe_ready_o;
  mem_wb_t  wb_o;
  logic     wb_ready;
  wb_req_t  bus_req;
  wb_rsp_t  bus_rsp;

  logic [31:0] mem     [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  exp_t        exp_q [$];

  logic [31:0]      lfsr_q;
  logic             stall_en;
  logic             beat_busy;
  int               wait_left;
  int               cycles;
  int               errors;
  int               checks;
  int               tests_run;
  int               tests_failed;
  string            cur_test;
  logic [ROB_W-1:0] rob_cnt;

  lsu_top #(
    .LINES          (8),
    .WORDS_PER_LINE (4),
    .PT_BASE        (32'h0000_8000)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .exe_i       (exe_i),
    .exe_ready_o (exe_ready_o),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready),
    .bus_o       (bus_req),
    .bus_i       (bus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // ==================================================
  // Wishbone slave and wb_ready stalls
  // ==================================================
  always @(posedge clk) begin : slave_proc
    logic        ack_nxt;
    logic [31:0] dat_nxt;
    logic        rdy_nxt;
    int          widx;
    ack_nxt = 1'b0;
    dat_nxt = bus_rsp.dat_r;
    rdy_nxt = 1'b1;
    widx    = int'(bus_req.adr[15:2]);
    if (stall_en) begin
      rdy_nxt = next_bits(2) != 32'd0;
    end
    // Ack high now means the beat completes on this edge
    if (rst_n && !bus_rsp.ack && bus_req.cyc && bus_req.stb) begin
      if (!beat_busy) begin
        beat_busy = 1'b1;
        wait_left = 1 + int'(next_bits(2) % 3);
      end
      wait_left--;
      if (wait_left == 0) begin
        beat_busy = 1'b0;
        ack_nxt   = 1'b1;
        if (bus_req.we) begin
          mem[widx] = bus_req.dat_w;
        end else begin
          dat_nxt = mem[widx];
        end
      end
    end
    #1;
    bus_rsp.ack   = ack_nxt;
    bus_rsp.dat_r = dat_nxt;
    wb_ready      = rdy_nxt;
  end

  // ==================================================
  // Write-back monitor, sampled mid-cycle
  // ==================================================
  always @(negedge clk) begin : wb_monitor
    exp_t e;
    if (rst_n && wb_o.valid && wb_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: write-back seen with no operation outstanding", cur_test);
      end else begin
        e = exp_q.pop_front();
        check_val("rob_idx", 32'(e.rob), 32'(wb_o.rob_idx));
        check_val("pdest", 32'(e.pdest), 32'(wb_o.pdest));
        check_val("op", 32'(e.op), 32'(wb_o.op));
        check_val("excp", 32'(e.excp), 32'(wb_o.excp));
        check_val("we", 32'(e.we), 32'(wb_o.we));
        check_val("vaddr", e.vaddr, wb_o.vaddr);
        if (e.chk_paddr) begin
          check_val("paddr", e.paddr, wb_o.paddr);
        end
        if (e.chk_wdata) begin
          check_val("wdata", e.wdata, wb_o.wdata);
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run exceeded %0d cycles with %0d operations outstanding",
               CYCLE_LIMIT, exp_q.size());
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Model result pushed, then the op is held until accepted
  task automatic send_op(input mem_op_e op, input logic [3:0] vpn, input logic [3:0] off,
                         input logic [31:0] data, input logic pv);
    exp_t        e;
    logic        fault;
    logic        rdy;
    logic [31:0] pa;
    fault = vpn[3] && (op != CACOP);
    pa    = {17'h0, vpn[2:0] ^ 3'd3, 6'h0, off, 2'b00};
    e.rob       = rob_cnt;
    e.pdest     = 6'(rob_cnt) + 6'd1;
    e.op        = op;
    e.vaddr     = {16'h0, vpn, 6'h0, off, 2'b00};
    e.excp      = fault;
    e.we        = (op == LOAD) && pv && !fault;
    e.paddr     = (op == CACOP) ? e.vaddr : pa;
    e.chk_paddr = !fault;
    e.chk_wdata = !fault;
    e.wdata     = '0;
    if (op == LOAD && !fault) begin
      e.wdata = ref_mem[pa[15:2]];
    end
    if (op == STORE && !fault) begin
      ref_mem[pa[15:2]] = data;
    end
    exp_q.push_back(e);
    exe_i.valid       = 1'b1;
    exe_i.op          = op;
    exe_i.base        = {16'h0, vpn, 12'h0};
    exe_i.imm         = {6'h0, off, 2'b00};
    exe_i.wdata       = data;
    exe_i.rob_idx     = rob_cnt;
    exe_i.pdest       = e.pdest;
    exe_i.pdest_valid = pv;
    rob_cnt++;
    rdy = 1'b0;
    while (!rdy) begin
      @(negedge clk);
      rdy = exe_ready_o;
      @(posedge clk);
    end
    #1;
    exe_i.valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic compare_memory();
    int bad;
    bad = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (mem[i] !== ref_mem[i]) begin
        bad++;
      end
    end
    check_val("memory mismatches", 32'd0, 32'(bad));
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    tests_run++;
  endtask

  task automatic end_test(input int errs_before);
    if (errors == errs_before) begin
      $display("test %-22s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %-22s failed with %0d errors", cur_test, errors - errs_before);
    end
  endtask

  // ==================================================
  // Sequence
  // ==================================================
  initial begin : main_seq
    int          e0;
    logic [3:0]  vpn;
    logic [3:0]  off;
    logic [31:0] nv;
    logic [1:0]  sel;
    rst_n     = 1'b0;
    exe_i     = '0;
    wb_ready  = 1'b1;
    bus_rsp   = '0;
    stall_en  = 1'b0;
    beat_busy = 1'b0;
    wait_left = 0;
    lfsr_q    = 32'd97;
    cycles    = 0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    tests_failed = 0;
    rob_cnt   = '0;
    cur_test  = "reset";
    // Fill pattern from the full word address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {~i[15:0], i[15:0]} ^ 32'h5A00_0000;
    end
    // Page table, vpn 0..7 valid, 8..15 invalid
    for (int v = 0; v < 16; v++) begin
      mem[PT_WORD + v] = (v < 8) ? {17'h0, 3'(v) ^ 3'd3, 12'h001} : 32'h0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = mem[i];
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("load_valid_page");
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      vpn = {1'b0, 3'(next_bits(3))};
      off = 4'(next_bits(4));
      send_op(LOAD, vpn, off, '0, 1'(next_bits(1)));
    end
    drain();
    end_test(e0);

    start_test("store_then_load");
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      vpn = {1'b0, 3'(next_bits(3))};
      off = 4'(next_bits(4));
      // First load caches the line so the store hits
      send_op(LOAD, vpn, off, '0, 1'b1);
      send_op(STORE, vpn, off, next_bits(32), 1'b0);
      send_op(LOAD, vpn, off, '0, 1'b1);
    end
    drain();
    compare_memory();
    end_test(e0);

    start_test("translation_fault");
    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      vpn = {1'b1, 3'(next_bits(3))};
      off = 4'(next_bits(4));
      send_op((i % 2 == 0) ? STORE : LOAD, vpn, off, next_bits(32), 1'b1);
    end
    drain();
    compare_memory();
    end_test(e0);

    start_test("cacop_invalidate");
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      vpn = 4'(i);
      off = 4'((i * 5) % 16);
      send_op(LOAD, vpn, off, '0, 1'b1);
      send_op(CACOP, vpn, off, '0, 1'b0);
      drain();
      // Memory changed behind the cache
      nv = next_bits(32);
      mem[{vpn[2:0] ^ 3'd3, 6'h0, off}]     = nv;
      ref_mem[{vpn[2:0] ^ 3'd3, 6'h0, off}] = nv;
      send_op(LOAD, vpn, off, '0, 1'b1);
      drain();
    end
    end_test(e0);

    start_test("back_pressure");
    e0 = errors;
    stall_en = 1'b1;
    for (int i = 0; i < 60; i++) begin
      sel = 2'(next_bits(2) % 3);
      vpn = 4'(next_bits(4));
      off = 4'(next_bits(4));
      send_op(mem_op_e'(sel), vpn, off, next_bits(32), 1'(next_bits(1)));
    end
    drain();
    stall_en = 1'b0;
    compare_memory();
    end_test(e0);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/lsu_tb_properties.sv
// Bus and write-back protocol assertions
// Bound to the arbiter and the memory block
`timescale 1ns/10ps
`default_nettype none

module lsu_tb_properties
  import lsu_pkg::*, bus_pkg::*;
(
  input wire        clk,
  input wire        rst_n,
  input wb_req_t    req,
  input wire        ack,
  input wire [1:0]  master_cyc,
  input mem_wb_t    wb,
  input wire        wb_ready
);

  // Strobe only inside a cycle
  stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n) req.stb |-> req.cyc)
    else $error("stb high without cyc");

  // Address held until ack
  adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (req.stb && !ack) |=> $stable(req.adr))
    else $error("adr changed during a pending beat");

  // Walker and cache never run bus cycles together
  one_owner: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(master_cyc))
    else $error("both masters hold a bus cycle");

  // Write-back held under back-pressure
  wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (wb.valid && !wb_ready) |=> $stable(wb))
    else $error("wb_o changed while stalled");

endmodule

bind wb_arbiter lsu_tb_properties u_arb_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .req        (bus_o),
  .ack        (bus_i.ack),
  .master_cyc ({m1_req_i.cyc, m0_req_i.cyc}),
  .wb         ('0),
  .wb_ready   (1'b1)
);

bind mem_block lsu_tb_properties u_mem_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .req        (dc_bus_o),
  .ack        (dc_bus_i.ack),
  .master_cyc (2'b00),
  .wb         (wb_o),
  .wb_ready   (wb_ready_i)
);

`default_nettype wire

// File: verilog/lsu_top.sv
// Load/store unit top level
// Memory block, walker and bus arbiter on one Wishbone port
`timescale 1ns/10ps
`default_nettype none

module lsu_top
  import lsu_pkg::*, bus_pkg::*;
#(
  parameter int          LINES          = 8,
  parameter int          WORDS_PER_LINE = 4,
  parameter logic [31:0] PT_BASE        = 32'h0000_8000
) (
  input  wire      clk,
  input  wire      rst_n,
  input  mem_exe_t exe_i,
  output logic     exe_ready_o,
  output mem_wb_t  wb_o,
  input  wire      wb_ready_i,
  output wb_req_t  bus_o,
  input  wb_rsp_t  bus_i
);

  xlate_req_t xlate_req;
  xlate_rsp_t xlate_rsp;
  // Per-master bus bundles
  wb_req_t    pw_bus_req;
  wb_rsp_t    pw_bus_rsp;
  wb_req_t    dc_bus_req;
  wb_rsp_t    dc_bus_rsp;

  mem_block #(
    .LINES          (LINES),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_mem_block (
    .clk         (clk),
    .rst_n       (rst_n),
    .exe_i       (exe_i),
    .exe_ready_o (exe_ready_o),
    .xlate_req_o (xlate_req),
    .xlate_rsp_i (xlate_rsp),
    .dc_bus_o    (dc_bus_req),
    .dc_bus_i    (dc_bus_rsp),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i)
  );

  page_walker #(
    .PT_BASE (PT_BASE)
  ) u_page_walker (
    .clk         (clk),
    .rst_n       (rst_n),
    .xlate_req_i (xlate_req),
    .xlate_rsp_o (xlate_rsp),
    .bus_o       (pw_bus_req),
    .bus_i       (pw_bus_rsp)
  );

  // Walker on the priority port
  wb_arbiter u_wb_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .m0_req_i (pw_bus_req),
    .m1_req_i (dc_bus_req),
    .m0_rsp_o (pw_bus_rsp),
    .m1_rsp_o (dc_bus_rsp),
    .bus_o    (bus_o),
    .bus_i    (bus_i)
  );

endmodule

`default_nettype wire

// File: verilog/wb_arbiter.sv
// Two-master Wishbone arbiter
// Walker has priority, grant held for the owner's whole cycle
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter
  import bus_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  // m0 is the walker, m1 the cache
  input  wb_req_t m0_req_i,
  input  wb_req_t m1_req_i,
  output wb_rsp_t m0_rsp_o,
  output wb_rsp_t m1_rsp_o,
  // Shared bus
  output wb_req_t bus_o,
  input  wb_rsp_t bus_i
);

  // One-hot grant, zero when idle
  logic [1:0] gnt_q;
  logic [1:0] gnt_d;
  logic       owner_done;

  // Owner released the bus
  assign owner_done = (gnt_q[0] & ~m0_req_i.cyc) | (gnt_q[1] & ~m1_req_i.cyc);

  always_comb begin
    gnt_d = gnt_q;
    if (gnt_q == 2'b00 || owner_done) begin
      if (m0_req_i.cyc) begin
        gnt_d = 2'b01;
      end else if (m1_req_i.cyc) begin
        gnt_d = 2'b10;
      end else begin
        gnt_d = 2'b00;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_q <= 2'b00;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  // Bus follows the registered grant
  always_comb begin
    if (gnt_q[0]) begin
      bus_o = m0_req_i;
    end else if (gnt_q[1]) begin
      bus_o = m1_req_i;
    end else begin
      bus_o = '0;
    end

    // Ack steered to the owner only
    m0_rsp_o.ack   = bus_i.ack & gnt_q[0];
    m0_rsp_o.dat_r = bus_i.dat_r;
    m1_rsp_o.ack   = bus_i.ack & gnt_q[1];
    m1_rsp_o.dat_r = bus_i.dat_r;
  end

endmodule

`default_nettype wire

// File: verilog/page_walker.sv
// TLB and page-table walker
// Four fully associative entries, single-level walk over Wishbone
`timescale 1ns/10ps
`default_nettype none

module page_walker
  import lsu_pkg::*, bus_pkg::*;
#(
  parameter logic [31:0] PT_BASE = 32'h0000_8000
) (
  input  wire        clk,
  input  wire        rst_n,
  input  xlate_req_t xlate_req_i,
  output xlate_rsp_t xlate_rsp_o,
  output wb_req_t    bus_o,
  input  wb_rsp_t    bus_i
);

  localparam int TLB_N = 4;

  typedef enum logic [1:0] {
    PW_IDLE, PW_WALK, PW_DONE
  } pw_state_e;

  pw_state_e        state_q;
  logic [TLB_N-1:0] tlb_valid_q;
  logic [VPN_W-1:0] tlb_vpn_q [TLB_N];
  logic [PPN_W-1:0] tlb_ppn_q [TLB_N];
  logic [1:0]       rr_q;

  // Walk result
  logic [VPN_W-1:0] vpn_q;
  logic [PPN_W-1:0] ppn_q;
  logic             fault_q;

  logic             tlb_hit;
  logic [PPN_W-1:0] hit_ppn;
  logic             pte_ok;

  // Fully associative match
  always_comb begin
    tlb_hit = 1'b0;
    hit_ppn = '0;
    for (int i = 0; i < TLB_N; i++) begin
      if (tlb_valid_q[i] && tlb_vpn_q[i] == xlate_req_i.vpn) begin
        tlb_hit = 1'b1;
        hit_ppn = tlb_ppn_q[i];
      end
    end
  end

  // PTE valid bit
  assign pte_ok = bus_i.dat_r[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= PW_IDLE;
      tlb_valid_q <= '0;
      rr_q        <= '0;
    end else begin
      case (state_q)
        PW_IDLE: begin
          if (xlate_req_i.valid && !tlb_hit) begin
            state_q <= PW_WALK;
          end
        end
        PW_WALK: begin
          if (bus_i.ack) begin
            state_q <= PW_DONE;
            // Faulting entries are never installed
            if (pte_ok) begin
              tlb_valid_q[rr_q] <= 1'b1;
              rr_q              <= rr_q + 1'b1;
            end
          end
        end
        default: state_q <= PW_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == PW_IDLE && xlate_req_i.valid && !tlb_hit) begin
      vpn_q <= xlate_req_i.vpn;
    end
    if (state_q == PW_WALK && bus_i.ack) begin
      ppn_q   <= bus_i.dat_r[WB_DW-1 -: PPN_W];
      fault_q <= ~pte_ok;
      if (pte_ok) begin
        tlb_vpn_q[rr_q] <= vpn_q;
        tlb_ppn_q[rr_q] <= bus_i.dat_r[WB_DW-1 -: PPN_W];
      end
    end
  end

  // Hit answers in the request cycle, a walk answers from PW_DONE
  always_comb begin
    xlate_rsp_o.valid = (state_q == PW_IDLE & xlate_req_i.valid & tlb_hit) |
                        (state_q == PW_DONE);
    xlate_rsp_o.ppn   = (state_q == PW_DONE) ? ppn_q : hit_ppn;
    xlate_rsp_o.fault = (state_q == PW_DONE) & fault_q;
  end

  // One read of the PTE at PT_BASE + 4*vpn
  always_comb begin
    bus_o.cyc   = state_q == PW_WALK;
    bus_o.stb   = state_q == PW_WALK;
    bus_o.we    = 1'b0;
    bus_o.adr   = PT_BASE + {{(WB_AW-VPN_W-2){1'b0}}, vpn_q, 2'b00};
    bus_o.dat_w = '0;
    bus_o.sel   = '1;
  end

endmodule

`default_nettype wire

// File: verilog/mem_block.sv
// Memory-access stage
// Stage 1 register, address generation, data cache and write-back
`timescale 1ns/10ps
`default_nettype none

module mem_block
  import lsu_pkg::*, bus_pkg::*;
#(
  parameter int LINES          = 8,
  parameter int WORDS_PER_LINE = 4
) (
  input  wire         clk,
  input  wire         rst_n,
  // Execute side
  input  mem_exe_t    exe_i,
  output logic        exe_ready_o,
  // Translation
  output xlate_req_t  xlate_req_o,
  input  xlate_rsp_t  xlate_rsp_i,
  // Cache bus master
  output wb_req_t     dc_bus_o,
  input  wb_rsp_t     dc_bus_i,
  // Write-back
  output mem_wb_t     wb_o,
  input  wire         wb_ready_i
);

  mem_exe_t    s1_q;
  dcache_req_t dc_req;
  dcache_rsp_t dc_rsp;
  logic        dc_req_ready;

  // ==================================================
  // Stage 1
  // ==================================================

  // Free slot or the held request leaves this cycle
  assign exe_ready_o = ~s1_q.valid | dc_req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_q <= '0;
    end else if (exe_ready_o) begin
      s1_q <= exe_i;
    end
  end

  // Address generation from the held operands
  always_comb begin
    dc_req.valid       = s1_q.valid;
    dc_req.op          = s1_q.op;
    dc_req.vaddr       = s1_q.base + {{(XLEN-IMM_W){s1_q.imm[IMM_W-1]}}, s1_q.imm};
    dc_req.wdata       = s1_q.wdata;
    dc_req.rob_idx     = s1_q.rob_idx;
    dc_req.pdest       = s1_q.pdest;
    dc_req.pdest_valid = s1_q.pdest_valid;
  end

  // Multi-cycle cache, busy until its response is taken
  dcache #(
    .LINES          (LINES),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_dcache (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (dc_req),
    .req_ready_o (dc_req_ready),
    .rsp_o       (dc_rsp),
    .rsp_ready_i (wb_ready_i),
    .xlate_req_o (xlate_req_o),
    .xlate_rsp_i (xlate_rsp_i),
    .bus_o       (dc_bus_o),
    .bus_i       (dc_bus_i)
  );

  // ==================================================
  // Write-back
  // ==================================================

  // Only an unfaulted load writes the register file
  always_comb begin
    wb_o.valid   = dc_rsp.valid;
    wb_o.we      = (dc_rsp.op == LOAD) & dc_rsp.pdest_valid & ~dc_rsp.excp;
    wb_o.wdata   = (dc_rsp.op == LOAD) ? dc_rsp.rdata : '0;
    wb_o.rob_idx = dc_rsp.rob_idx;
    wb_o.pdest   = dc_rsp.pdest;
    wb_o.excp    = dc_rsp.excp;
    wb_o.vaddr   = dc_rsp.vaddr;
    wb_o.paddr   = dc_rsp.paddr;
    wb_o.op      = dc_rsp.op;
  end

endmodule

`default_nettype wire

// File: verilog/dcache.sv
// Direct-mapped write-through data cache
// Translates via the walker, refills lines and writes through over Wishbone
`timescale 1ns/10ps
`default_nettype none

module dcache
  import lsu_pkg::*, bus_pkg::*;
#(
  parameter int LINES          = 8,
  parameter int WORDS_PER_LINE = 4
) (
  input  wire         clk,
  input  wire         rst_n,
  input  dcache_req_t req_i,
  output logic        req_ready_o,
  output dcache_rsp_t rsp_o,
  input  wire         rsp_ready_i,
  output xlate_req_t  xlate_req_o,
  input  xlate_rsp_t  xlate_rsp_i,
  output wb_req_t     bus_o,
  input  wb_rsp_t     bus_i
);

  localparam int OFF_W   = $clog2(WORDS_PER_LINE);
  localparam int IDX_W   = $clog2(LINES);
  localparam int TAG_LSB = 2 + OFF_W + IDX_W;
  localparam int TAG_W   = XLEN - TAG_LSB;

  typedef enum logic [2:0] {
    IDLE, XLATE, LOOKUP, REFILL, WRITE, RESP
  } dc_state_e;

  dc_state_e   state_q;
  dcache_req_t req_q;
  logic [XLEN-1:0]  paddr_q;
  logic [XLEN-1:0]  rdata_q;
  logic             excp_q;
  logic [OFF_W-1:0] beat_q;
  wb_req_t          bus_q;

  // Tag, valid and data arrays
  logic [LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_q  [LINES];
  logic [XLEN-1:0]  data_q [LINES][WORDS_PER_LINE];

  logic [IDX_W-1:0]       idx;
  logic [OFF_W-1:0]       off;
  logic [TAG_W-1:0]       tag;
  logic [XLEN-3-OFF_W:0]  line_base;
  logic [OFF_W-1:0]       beat_nxt;
  logic                   hit;
  logic                   beat_ack;
  logic                   last_beat;

  // Index from the page offset, so vaddr and paddr agree
  always_comb begin
    idx       = req_q.vaddr[2+OFF_W +: IDX_W];
    off       = req_q.vaddr[2 +: OFF_W];
    tag       = paddr_q[TAG_LSB +: TAG_W];
    line_base = paddr_q[XLEN-1:2+OFF_W];
    beat_nxt  = beat_q + 1'b1;
    hit       = valid_q[idx] & (tag_q[idx] == tag);
    beat_ack  = (state_q == REFILL) & bus_i.ack;
    last_beat = beat_q == OFF_W'(WORDS_PER_LINE - 1);
  end

  // ==================================================
  // Control
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
      bus_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          // Index invalidate skips translation
          if (req_i.valid) begin
            state_q <= (req_i.op == CACOP) ? LOOKUP : XLATE;
          end
        end
        XLATE: begin
          if (xlate_rsp_i.valid) begin
            state_q <= xlate_rsp_i.fault ? RESP : LOOKUP;
          end
        end
        LOOKUP: begin
          if (req_q.op == LOAD && !hit) begin
            // Load miss, fetch the line from word 0
            state_q     <= REFILL;
            beat_q      <= '0;
            bus_q.cyc   <= 1'b1;
            bus_q.stb   <= 1'b1;
            bus_q.we    <= 1'b0;
            bus_q.adr   <= {line_base, {OFF_W{1'b0}}, 2'b00};
            bus_q.dat_w <= '0;
            bus_q.sel   <= '1;
          end else if (req_q.op == STORE) begin
            // Write through, hit or miss
            state_q     <= WRITE;
            bus_q.cyc   <= 1'b1;
            bus_q.stb   <= 1'b1;
            bus_q.we    <= 1'b1;
            bus_q.adr   <= {paddr_q[XLEN-1:2], 2'b00};
            bus_q.dat_w <= req_q.wdata;
            bus_q.sel   <= '1;
          end else begin
            state_q <= RESP;
          end
        end
        REFILL: begin
          if (bus_i.ack) begin
            if (last_beat) begin
              bus_q.cyc <= 1'b0;
              bus_q.stb <= 1'b0;
              state_q   <= RESP;
            end else begin
              // Next beat, cyc stays up
              beat_q    <= beat_nxt;
              bus_q.adr <= {line_base, beat_nxt, 2'b00};
            end
          end
        end
        WRITE: begin
          if (bus_i.ack) begin
            bus_q.cyc <= 1'b0;
            bus_q.stb <= 1'b0;
            state_q   <= RESP;
          end
        end
        RESP: begin
          if (rsp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request payload and result
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i.valid) begin
      req_q   <= req_i;
      paddr_q <= req_i.vaddr;
      excp_q  <= 1'b0;
    end
    if (state_q == XLATE && xlate_rsp_i.valid) begin
      paddr_q <= {xlate_rsp_i.ppn, req_q.vaddr[PAGE_OFF_W-1:0]};
      excp_q  <= xlate_rsp_i.fault;
    end
    if (state_q == LOOKUP && hit) begin
      rdata_q <= data_q[idx][off];
    end
    // Requested word picked off the refill
    if (beat_ack && beat_q == off) begin
      rdata_q <= bus_i.dat_r;
    end
  end

  // ==================================================
  // Arrays
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (state_q == LOOKUP && req_q.op == CACOP) begin
      valid_q[idx] <= 1'b0;
    end else if (beat_ack && last_beat) begin
      valid_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_ack) begin
      data_q[idx][beat_q] <= bus_i.dat_r;
    end
    if (beat_ack && last_beat) begin
      tag_q[idx] <= tag;
    end
    // Store hit updates the line, a miss does not allocate
    if (state_q == LOOKUP && req_q.op == STORE && hit) begin
      data_q[idx][off] <= req_q.wdata;
    end
  end

  // ==================================================
  // Outputs
  // ==================================================
  always_comb begin
    req_ready_o = state_q == IDLE;

    xlate_req_o.valid = state_q == XLATE;
    xlate_req_o.vpn   = req_q.vaddr[XLEN-1 -: VPN_W];

    rsp_o.valid       = state_q == RESP;
    rsp_o.op          = req_q.op;
    rsp_o.vaddr       = req_q.vaddr;
    rsp_o.paddr       = paddr_q;
    rsp_o.rdata       = rdata_q;
    rsp_o.rob_idx     = req_q.rob_idx;
    rsp_o.pdest       = req_q.pdest;
    rsp_o.pdest_valid = req_q.pdest_valid;
    rsp_o.excp        = excp_q;

    bus_o = bus_q;
  end

endmodule

`default_nettype wire

// File: verilog/bus_pkg.sv
// Wishbone classic bus definitions
// Master and slave signal bundles, bus widths
`default_nettype none

package bus_pkg;

  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  localparam int WB_SW = WB_DW / 8;

  // Master to slave
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat_w;
    logic [WB_SW-1:0] sel;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire

// File: verilog/lsu_pkg.sv
// Load/store datapath definitions
// Opcodes, stage records, cache and translation handshakes
`default_nettype none

package lsu_pkg;

  // Datapath widths
  localparam int XLEN       = 32;
  localparam int ROB_W      = 5;
  localparam int PDEST_W    = 6;
  localparam int IMM_W      = 12;
  localparam int PAGE_OFF_W = 12;
  localparam int VPN_W      = XLEN - PAGE_OFF_W;
  localparam int PPN_W      = 20;

  // Memory operation
  typedef enum logic [1:0] {
    LOAD  = 2'd0,
    STORE = 2'd1,
    CACOP = 2'd2
  } mem_op_e;

  // Execute stage output into the memory block
  typedef struct packed {
    logic               valid;
    mem_op_e            op;
    logic [XLEN-1:0]    base;
    logic [IMM_W-1:0]   imm;
    logic [XLEN-1:0]    wdata;
    logic [ROB_W-1:0]   rob_idx;
    logic [PDEST_W-1:0] pdest;
    logic               pdest_valid;
  } mem_exe_t;

  // Stage 1 into the data cache
  typedef struct packed {
    logic               valid;
    mem_op_e            op;
    logic [XLEN-1:0]    vaddr;
    logic [XLEN-1:0]    wdata;
    logic [ROB_W-1:0]   rob_idx;
    logic [PDEST_W-1:0] pdest;
    logic               pdest_valid;
  } dcache_req_t;

  // Data cache completion, held until taken
  typedef struct packed {
    logic               valid;
    mem_op_e            op;
    logic [XLEN-1:0]    vaddr;
    logic [XLEN-1:0]    paddr;
    logic [XLEN-1:0]    rdata;
    logic [ROB_W-1:0]   rob_idx;
    logic [PDEST_W-1:0] pdest;
    logic               pdest_valid;
    logic               excp;
  } dcache_rsp_t;

  // Translation request and answer
  typedef struct packed {
    logic             valid;
    logic [VPN_W-1:0] vpn;
  } xlate_req_t;

  typedef struct packed {
    logic             valid;
    logic [PPN_W-1:0] ppn;
    logic             fault;
  } xlate_rsp_t;

  // Write-back record
  typedef struct packed {
    logic               valid;
    logic               we;
    logic [XLEN-1:0]    wdata;
    logic [ROB_W-1:0]   rob_idx;
    logic [PDEST_W-1:0] pdest;
    logic               excp;
    logic [XLEN-1:0]    vaddr;
    logic [XLEN-1:0]    paddr;
    mem_op_e            op;
  } mem_wb_t;

endpackage

`default_nettype wire
